//--- beam_mac.sv
/*
 * beam MAC: weight store, RE counter and rbG-last marking,
 * then complex products (stage 1) and antenna sum per beam (stage 2)
 */
`include "pdsch_dr_defs.svh"

module beam_mac (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  pdsch_dr_pkg::ant_vec_t  i_ant,
    input  pdsch_dr_pkg::rbg_size_t i_rbg_size,
    input  logic                   i_wt_wr,
    input  pdsch_dr_pkg::wt_wr_t    i_wt,
    output pdsch_dr_pkg::beam_iq_t  o_beam,
    output pdsch_dr_pkg::re_ctl_t   o_ctl
);

    localparam int CNT_W  = $clog2(`DR_RE_192);
    localparam int PROD_W = `DR_IQ_W + `DR_WT_W + 1;

    pdsch_dr_pkg::wt_t      wt_mem [`DR_BEAM][`DR_ANT];
    logic [CNT_W-1:0]       re_cnt;
    logic [CNT_W-1:0]       re_len;
    logic [CNT_W-1:0]       cur_len;
    logic                   re_last;
    pdsch_dr_pkg::re_ctl_t  ctl_in;
    logic signed [PROD_W-1:0] prod_i [`DR_BEAM][`DR_ANT];
    logic signed [PROD_W-1:0] prod_q [`DR_BEAM][`DR_ANT];
    pdsch_dr_pkg::beam_iq_t sum_c;

    function automatic logic [CNT_W-1:0] rbg_len(input pdsch_dr_pkg::rbg_size_t size);
        case (size)
            pdsch_dr_pkg::RBG8:  return CNT_W'(`DR_RE_96);
            pdsch_dr_pkg::RBG16: return CNT_W'(`DR_RE_192);
            default:             return CNT_W'(`DR_RE_48);
        endcase
    endfunction

    // --------------------
    // weight store
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int b = 0; b < `DR_BEAM; b++) begin
                for (int a = 0; a < `DR_ANT; a++) begin
                    wt_mem[b][a] <= '0;
                end
            end
        end else if (i_wt_wr) begin
            wt_mem[i_wt.beam][i_wt.ant] <= i_wt.w;
        end
    end

    // --------------------
    // RE counter, size only taken at rbG start
    assign cur_len = (re_cnt == '0) ? rbg_len(i_rbg_size) : re_len;
    assign re_last = i_valid && (re_cnt == cur_len - 1'b1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt <= '0;
            re_len <= CNT_W'(`DR_RE_48);
        end else if (i_valid) begin
            if (re_cnt == '0) begin
                re_len <= cur_len;
            end
            re_cnt <= re_last ? '0 : re_cnt + 1'b1;
        end
    end

    assign ctl_in = '{valid: i_valid, last: re_last};

    stage_delay #(
        .T     (pdsch_dr_pkg::re_ctl_t),
        .DEPTH (2)
    ) u_ctl_dly (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  (ctl_in),
        .o_data  (o_ctl)
    );

    // --------------------
    // stage 1: (ai + j aq)(wi + j wq) for every beam and antenna
    always_ff @(posedge i_clk) begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            for (int a = 0; a < `DR_ANT; a++) begin
                prod_i[b][a] <= i_ant[a].i * wt_mem[b][a].i - i_ant[a].q * wt_mem[b][a].q;
                prod_q[b][a] <= i_ant[a].i * wt_mem[b][a].q + i_ant[a].q * wt_mem[b][a].i;
            end
        end
    end

    // stage 2: sum over antennas
    always_comb begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            sum_c[b].i = '0;
            sum_c[b].q = '0;
            for (int a = 0; a < `DR_ANT; a++) begin
                sum_c[b].i = sum_c[b].i + prod_i[b][a];
                sum_c[b].q = sum_c[b].q + prod_q[b][a];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_beam <= sum_c;
    end

endmodule

//--- beam_power.sv
/*
 * beam magnitude: arithmetic shift and |I|,|Q| (stage 1),
 * then |I|+|Q| per beam (stage 2)
 */
`include "pdsch_dr_defs.svh"

module beam_power (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  pdsch_dr_pkg::beam_iq_t i_beam,
    input  pdsch_dr_pkg::re_ctl_t  i_ctl,
    output pdsch_dr_pkg::beam_pwr_t o_pwr,
    output pdsch_dr_pkg::re_ctl_t  o_ctl
);

    logic signed [`DR_MAC_W-1:0] sft_i [`DR_BEAM];
    logic signed [`DR_MAC_W-1:0] sft_q [`DR_BEAM];
    pdsch_dr_pkg::beam_iq_t      abs_c;
    pdsch_dr_pkg::beam_iq_t      abs_q;

    // shift then fold sign, magnitude fits in PWR_W-1 bits
    always_comb begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            sft_i[b] = i_beam[b].i >>> `DR_SHIFT;
            sft_q[b] = i_beam[b].q >>> `DR_SHIFT;
            abs_c[b].i = sft_i[b][`DR_MAC_W-1] ? -sft_i[b] : sft_i[b];
            abs_c[b].q = sft_q[b][`DR_MAC_W-1] ? -sft_q[b] : sft_q[b];
        end
    end

    stage_delay #(
        .T     (pdsch_dr_pkg::beam_iq_t),
        .DEPTH (1)
    ) u_abs_reg (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  (abs_c),
        .o_data  (abs_q)
    );

    always_ff @(posedge i_clk) begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            o_pwr[b] <= {1'b0, abs_q[b].i[`DR_PWR_W-2:0]} + {1'b0, abs_q[b].q[`DR_PWR_W-2:0]};
        end
    end

    stage_delay #(
        .T     (pdsch_dr_pkg::re_ctl_t),
        .DEPTH (2)
    ) u_ctl_dly (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_data  (i_ctl),
        .o_data  (o_ctl)
    );

endmodule

//--- pdsch_dr.f
+incdir+.
pdsch_dr_pkg.sv
stage_delay.sv
beam_mac.sv
beam_power.sv
rbg_accumulator.sv
pdsch_dr_core.sv
pdsch_dr_assertions.sv
pdsch_dr_tb.sv

//--- pdsch_dr_assertions.sv
/*
 * output protocol checks for the dimension reduction core
 * result pulse shape and held results
 */
module pdsch_dr_assertions (
    input logic                    i_clk,
    input logic                    i_reset,
    input logic                    i_rbg_vld,
    input pdsch_dr_pkg::beam_acc_t i_rbg_sum,
    input logic [1:0]              i_best_beam
);

    timeunit 1ns;
    timeprecision 100ps;

    int n_fail = 0;

    // low through reset and the first cycle after it
    a_vld_reset: assert property (@(posedge i_clk) i_reset |=> !i_rbg_vld [*2])
        else begin
            n_fail++;
            $error("o_rbg_vld high during or right after reset");
        end

    a_vld_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
                                  i_rbg_vld |=> !i_rbg_vld)
        else begin
            n_fail++;
            $error("o_rbg_vld high for more than one cycle");
        end

    // results only move together with the pulse
    a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
                             !i_rbg_vld |-> ($stable(i_rbg_sum) && $stable(i_best_beam)))
        else begin
            n_fail++;
            $error("rbG results changed without o_rbg_vld");
        end

endmodule

bind pdsch_dr_core pdsch_dr_assertions u_assert (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_rbg_vld   (o_rbg_vld),
    .i_rbg_sum   (o_rbg_sum),
    .i_best_beam (o_best_beam)
);

//--- pdsch_dr_core.sv
/*
 * PDSCH beam-domain dimension reduction core
 * beam MAC -> |I|+|Q| -> rbG sum and strongest beam
 */
module pdsch_dr_core (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_valid,
    input  pdsch_dr_pkg::ant_vec_t  i_ant,
    input  pdsch_dr_pkg::rbg_size_t i_rbg_size,
    input  logic                    i_wt_wr,
    input  pdsch_dr_pkg::wt_wr_t    i_wt,
    output logic                    o_rbg_vld,
    output pdsch_dr_pkg::beam_acc_t o_rbg_sum,
    output logic [1:0]              o_best_beam
);

    pdsch_dr_pkg::beam_iq_t  mac_beam;
    pdsch_dr_pkg::re_ctl_t   mac_ctl;
    pdsch_dr_pkg::beam_pwr_t pwr;
    pdsch_dr_pkg::re_ctl_t   pwr_ctl;

    // --------------------
    // 2 cycles, rbG-last marked here
    beam_mac u_beam_mac (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_ant      (i_ant),
        .i_rbg_size (i_rbg_size),
        .i_wt_wr    (i_wt_wr),
        .i_wt       (i_wt),
        .o_beam     (mac_beam),
        .o_ctl      (mac_ctl)
    );

    // 2 cycles
    beam_power u_beam_power (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_beam  (mac_beam),
        .i_ctl   (mac_ctl),
        .o_pwr   (pwr),
        .o_ctl   (pwr_ctl)
    );

    // 1 cycle to the result pulse
    rbg_accumulator u_rbg_acc (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_pwr       (pwr),
        .i_ctl       (pwr_ctl),
        .o_rbg_vld   (o_rbg_vld),
        .o_rbg_sum   (o_rbg_sum),
        .o_best_beam (o_best_beam)
    );

endmodule

//--- pdsch_dr_defs.svh
/*
 * beam-domain dimension reduction core
 * sizes, widths, scaling shift and rbG lengths
 */
`ifndef PDSCH_DR_DEFS_SVH
`define PDSCH_DR_DEFS_SVH

// --------------------
// array sizes
`define DR_ANT      4
`define DR_BEAM     4

// --------------------
// datapath widths
`define DR_IQ_W     16
`define DR_WT_W     8
// product is IQ_W+WT_W+1, four antennas add two more bits
`define DR_MAC_W    27
`define DR_SHIFT    4
`define DR_PWR_W    24
`define DR_ACC_W    32

// --------------------
// REs per rbG, 12 REs per PRB
`define DR_RE_48    48
`define DR_RE_96    96
`define DR_RE_192   192

`endif

//--- pdsch_dr_pkg.sv
/*
 * beam-domain dimension reduction core
 * sample, weight, beam and control types
 */
`include "pdsch_dr_defs.svh"

package pdsch_dr_pkg;

    // one complex antenna sample
    typedef struct packed {
        logic signed [`DR_IQ_W-1:0] i;
        logic signed [`DR_IQ_W-1:0] q;
    } iq_t;

    typedef iq_t [`DR_ANT-1:0] ant_vec_t;

    // one complex code-word weight
    typedef struct packed {
        logic signed [`DR_WT_W-1:0] i;
        logic signed [`DR_WT_W-1:0] q;
    } wt_t;

    typedef struct packed {
        logic [1:0] beam;
        logic [1:0] ant;
        wt_t        w;
    } wt_wr_t;

    // beam output after the antenna sum
    typedef struct packed {
        logic signed [`DR_MAC_W-1:0] i;
        logic signed [`DR_MAC_W-1:0] q;
    } beam_cplx_t;

    typedef beam_cplx_t [`DR_BEAM-1:0] beam_iq_t;

    typedef logic [`DR_BEAM-1:0][`DR_PWR_W-1:0] beam_pwr_t;
    typedef logic [`DR_BEAM-1:0][`DR_ACC_W-1:0] beam_acc_t;

    // code 3 falls back to RBG4
    typedef enum logic [1:0] {
        RBG4  = 2'd0,
        RBG8  = 2'd1,
        RBG16 = 2'd2
    } rbg_size_t;

    // flags that follow each RE down the pipeline
    typedef struct packed {
        logic valid;
        logic last;
    } re_ctl_t;

endpackage

//--- pdsch_dr_tb.sv
/*
 * testbench for the beam-domain dimension reduction core
 * replays weight loads and rbG tests from a trace, checks sums and best beam
 */
`include "pdsch_dr_defs.svh"

module pdsch_dr_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;

    // one trace step holds a weight write or an rbG test
    typedef struct packed {
        logic                    is_wt;
        pdsch_dr_pkg::wt_wr_t    wt;
        logic [1:0]              size;
        logic                    gaps;
        pdsch_dr_pkg::ant_vec_t  ant;
        logic [7:0]              n_rbg;
        logic [1:0]              best;
        pdsch_dr_pkg::beam_acc_t sums;
    } step_t;

    logic                    i_clk;
    logic                    i_reset;
    logic                    i_valid;
    pdsch_dr_pkg::ant_vec_t  i_ant;
    pdsch_dr_pkg::rbg_size_t i_rbg_size;
    logic                    i_wt_wr;
    pdsch_dr_pkg::wt_wr_t    i_wt;
    logic                    o_rbg_vld;
    pdsch_dr_pkg::beam_acc_t o_rbg_sum;
    logic [1:0]              o_best_beam;

    step_t       steps [$];
    logic [15:0] lfsr = 16'd45162;
    int          pulse_cnt = 0;
    int          rbg_done = 0;
    int          wd_cycles = 0;

    pdsch_dr_core UUT (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (i_valid),
        .i_ant       (i_ant),
        .i_rbg_size  (i_rbg_size),
        .i_wt_wr     (i_wt_wr),
        .i_wt        (i_wt),
        .o_rbg_vld   (o_rbg_vld),
        .o_rbg_sum   (o_rbg_sum),
        .o_best_beam (o_best_beam)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // result pulses seen since reset
    always @(posedge i_clk) begin
        if (!i_reset && o_rbg_vld) begin
            pulse_cnt <= pulse_cnt + 1;
        end
    end

    // any failed output protocol assertion ends the run
    always @(negedge i_clk) begin
        if (UUT.u_assert.n_fail != 0) begin
            abort_run("an output protocol assertion of the core failed");
        end
    end

    // --------------------
    // helpers
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // REs per rbG with code 3 counted as RBG4
    function automatic int re_per_rbg(input logic [1:0] size);
        case (size)
            2'd1:    return 96;
            2'd2:    return 192;
            default: return 48;
        endcase
    endfunction

    task automatic load_trace();
        int          fd;
        int          n;
        string       tag;
        string       line;
        logic [31:0] f [16];
        step_t       st;
        fd = $fopen("pdsch_dr_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file pdsch_dr_trace.txt");
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            st = '0;
            if (tag == "#") begin
                void'($fgets(line, fd));
            end else if (tag == "W") begin
                n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                if (n != 4) abort_run("weight line in the trace is incomplete");
                st.is_wt     = 1'b1;
                st.wt.beam   = f[0][1:0];
                st.wt.ant    = f[1][1:0];
                st.wt.w.i    = f[2][7:0];
                st.wt.w.q    = f[3][7:0];
                steps.push_back(st);
            end else if (tag == "T") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                if (n != 16) abort_run("test line in the trace is incomplete");
                st.size  = f[0][1:0];
                st.gaps  = f[1][0];
                st.n_rbg = f[2][7:0];
                st.best  = f[3][1:0];
                for (int a = 0; a < `DR_ANT; a++) begin
                    st.ant[a].i = f[4+2*a][15:0];
                    st.ant[a].q = f[5+2*a][15:0];
                end
                for (int b = 0; b < `DR_BEAM; b++) begin
                    st.sums[b] = f[12+b];
                end
                steps.push_back(st);
            end else begin
                abort_run($sformatf("unknown tag %s in the trace", tag));
            end
        end
        $fclose(fd);
    endtask

    task automatic write_weight(input pdsch_dr_pkg::wt_wr_t w);
        i_wt_wr = 1'b1;
        i_wt    = w;
        @(negedge i_clk);
        i_wt_wr = 1'b0;
        i_wt    = '0;
    endtask

    // --------------------
    // one rbG of constant REs followed by its result check
    task automatic run_rbg(input step_t st);
        int         n_re;
        logic [1:0] other;
        n_re  = re_per_rbg(st.size);
        // a different length is offered mid-rbG only
        other = (st.size == 2'd1) ? 2'd2 : 2'd1;
        for (int r = 0; r < n_re; r++) begin
            if (st.gaps) begin
                lfsr = lfsr_step(lfsr);
                if (lfsr[0]) begin
                    i_valid = 1'b0;
                    @(negedge i_clk);
                end
            end
            i_valid    = 1'b1;
            i_ant      = st.ant;
            i_rbg_size = pdsch_dr_pkg::rbg_size_t'((r == 0) ? st.size : other);
            @(negedge i_clk);
        end
        i_valid = 1'b0;
        i_ant   = '0;
        // pulse due 5 cycles after the last RE
        for (int c = 1; c < 5; c++) begin
            check_value("o_rbg_vld", o_rbg_vld, 32'd0);
            @(negedge i_clk);
        end
        check_value("o_rbg_vld", o_rbg_vld, 32'd1);
        check_value("o_best_beam", o_best_beam, st.best);
        for (int b = 0; b < `DR_BEAM; b++) begin
            check_value($sformatf("o_rbg_sum[%0d]", b), o_rbg_sum[b], st.sums[b]);
        end
        rbg_done++;
        @(negedge i_clk);
        check_value("rbG pulse count", pulse_cnt, rbg_done);
    endtask

    // --------------------
    // watchdog
    initial begin
        wait (wd_cycles > 0);
        #(wd_cycles * CLK_PERIOD);
        abort_run("watchdog expired before all rbG results arrived");
    end

    initial begin
        int total_re;
        int n_other;
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_ant      = '0;
        i_rbg_size = pdsch_dr_pkg::RBG4;
        i_wt_wr    = 1'b0;
        i_wt       = '0;
        total_re   = 0;
        n_other    = 0;
        load_trace();
        foreach (steps[k]) begin
            if (steps[k].is_wt) begin
                n_other += 2;
            end else begin
                total_re += steps[k].n_rbg * re_per_rbg(steps[k].size);
                n_other  += steps[k].n_rbg * 8;
            end
        end
        // every RE may carry one gap
        wd_cycles = 16 + 2 * total_re + n_other + 100;

        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);

        foreach (steps[k]) begin
            if (steps[k].is_wt) begin
                write_weight(steps[k].wt);
            end else begin
                for (int g = 0; g < steps[k].n_rbg; g++) begin
                    run_rbg(steps[k]);
                end
            end
        end

        repeat (4) @(negedge i_clk);
        if (UUT.u_assert.n_fail == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("%0d assertion failures on the core outputs", UUT.u_assert.n_fail);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

endmodule

//--- pdsch_dr_trace.txt
# W beam ant wt_i wt_q  (hex, weights 8-bit two's complement)
# T size gaps rbgs best a0i a0q a1i a1q a2i a2q a3i a3q sum0 sum1 sum2 sum3  (hex)
# diagonal weights, beam b follows antenna b
W 0 0 02 00
W 1 1 02 00
W 2 2 02 00
W 3 3 02 00
T 0 0 2 1 0100 0040 0200 0000 0080 0080 0010 0020 780 c00 600 120
T 0 1 1 1 0100 0040 0200 0000 0080 0080 0010 0020 780 c00 600 120
T 1 1 1 1 0100 0040 0200 0000 0080 0080 0010 0020 f00 1800 c00 240
T 2 0 1 1 0100 0040 0200 0000 0080 0080 0010 0020 1e00 3000 1800 480
T 3 0 1 1 0100 0040 0200 0000 0080 0080 0010 0020 780 c00 600 120
# negative weights and samples
W 0 0 fe 01
W 1 1 03 ff
W 2 2 ff ff
W 3 3 00 fe
T 0 0 1 2 ff9c 0025 fff9 fed4 03e8 fe0c ffdf 004d 3f0 e70 17a0 270
T 0 1 1 2 ff9c 0025 fff9 fed4 03e8 fe0c ffdf 004d 3f0 e70 17a0 270
# antenna 0 only, beam 3 strongest
W 0 0 01 00
W 1 0 00 02
W 2 0 fd 00
W 3 0 02 fe
T 0 0 1 3 0100 0000 0000 0000 0000 0000 0000 0000 300 600 900 c00
# beams 1 and 2 tie
W 3 0 00 00
W 1 0 fd 00
T 0 1 1 1 0100 0000 0000 0000 0000 0000 0000 0000 300 900 900 0

//--- rbg_accumulator.sv
/*
 * rbG accumulator: per-beam running sums over one rbG,
 * result capture and strongest-beam pick on the rbG-last RE
 */
`include "pdsch_dr_defs.svh"

module rbg_accumulator (
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  pdsch_dr_pkg::beam_pwr_t i_pwr,
    input  pdsch_dr_pkg::re_ctl_t   i_ctl,
    output logic                   o_rbg_vld,
    output pdsch_dr_pkg::beam_acc_t o_rbg_sum,
    output logic [1:0]             o_best_beam
);

    pdsch_dr_pkg::beam_acc_t acc;
    pdsch_dr_pkg::beam_acc_t acc_nxt;
    logic [1:0]              best_c;
    logic [`DR_ACC_W-1:0]    best_val;

    // running sum including the current RE
    always_comb begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            acc_nxt[b] = acc[b] + `DR_ACC_W'(i_pwr[b]);
        end
    end

    // --------------------
    // argmax, strict compare keeps the lower index on a tie
    always_comb begin
        best_c   = '0;
        best_val = acc_nxt[0];
        for (int b = 1; b < `DR_BEAM; b++) begin
            if (acc_nxt[b] > best_val) begin
                best_c   = 2'(b);
                best_val = acc_nxt[b];
            end
        end
    end

    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            acc       <= '0;
            o_rbg_vld <= 1'b0;
        end else begin
            o_rbg_vld <= i_ctl.valid && i_ctl.last;
            if (i_ctl.valid) begin
                // restart at zero for the next rbG
                acc <= i_ctl.last ? '0 : acc_nxt;
            end
        end
    end

    // results held until the next rbG completes
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rbg_sum   <= '0;
            o_best_beam <= '0;
        end else if (i_ctl.valid && i_ctl.last) begin
            o_rbg_sum   <= acc_nxt;
            o_best_beam <= best_c;
        end
    end

endmodule

//--- stage_delay.sv
/*
 * fixed-depth register pipeline for any packed payload
 * clears to zero on reset
 */
module stage_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic i_clk,
    input  logic i_reset,
    input  T     i_data,
    output T     o_data
);

    T pipe [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int s = 0; s < DEPTH; s++) begin
                pipe[s] <= '0;
            end
        end else begin
            pipe[0] <= i_data;
            for (int s = 1; s < DEPTH; s++) begin
                pipe[s] <= pipe[s-1];
            end
        end
    end

    assign o_data = pipe[DEPTH-1];

endmodule
